//--- all.f
verilog/iq_isa_pkg.sv
verilog/iq_queue_pkg.sv
verilog/iq_ptrs.sv
verilog/iq_fifo_mem.sv
verilog/iq_predecode.sv
verilog/iq_issue_decode.sv
verilog/iq_issue_queue.sv
dv/iq_tb.sv

//--- dv/iq_tb.sv
`timescale 1ns/100ps

module iq_tb;

  import iq_isa_pkg::*;
  import iq_queue_pkg::*;

  localparam int els_lp   = queue_els_gp;
  // reset plus the cycles planned for the six test groups, doubled
  localparam int limit_lp = 2 * (5 + 45 + 30 + 25 + 20 + 15 + 20);

  logic          clk_i = 1'b0;
  logic          arst_n_i;
  fe_packet_s    fe_packet_i;
  logic          fe_v_i, fe_ready_and_o;
  logic          read_v_i, deq_v_i, roll_v_i, clr_v_i, inject_v_i, suppress_v_i;
  preissue_pkt_s preissue_pkt_o;
  issue_pkt_s    issue_pkt_o;

  fe_packet_s model_q [$]; // uncommitted packets, oldest at the checkpoint
  int         m_rd   = 0;  // model read index into model_q
  int         reads  = 0;
  int         cycles = 0;
  int         errors = 0;
  integer     seed   = 38;
  logic       took   = 1'b0; // the offered packet was taken at the last rising edge

  opcode_e op_table [14] = '{e_lui_op, e_auipc_op, e_jal_op, e_jalr_op, e_branch_op,
                             e_load_op, e_store_op, e_op_imm_op, e_op_imm_32_op, e_op_op,
                             e_op_32_op, e_misc_mem_op, e_system_op, e_amo_op};

  iq_issue_queue #(.queue_els_p(els_lp)) i_iq_issue_queue (.*);

  always #50 clk_i = ~clk_i;

  function automatic issue_pkt_s ref_issue(input fe_packet_s pkt, input logic valid);
    issue_pkt_s exp;
    opcode_e    op;
    logic       fetch;
    exp   = '0;
    op    = pkt.instr.r.opcode;
    fetch = (pkt.msg_type == e_instr_fetch);
    if (valid)
    begin
      exp.v              = 1'b1;
      exp.instr_v        = fetch;
      exp.itlb_miss_v    = (pkt.msg_type == e_itlb_miss);
      exp.access_fault_v = (pkt.msg_type == e_access_fault);
      exp.page_fault_v   = (pkt.msg_type == e_page_fault);
      exp.pc             = pkt.pc;
      exp.instr          = pkt.instr;
    end
    if (valid && fetch)
    begin
      exp.rs1_v = op inside {e_jalr_op, e_load_op, e_op_imm_op, e_op_imm_32_op, e_system_op,
                             e_branch_op, e_store_op, e_op_op, e_op_32_op, e_amo_op};
      exp.rs2_v = op inside {e_branch_op, e_store_op, e_op_op, e_op_32_op, e_amo_op};
      exp.mem_v = op inside {e_load_op, e_store_op, e_amo_op, e_system_op};
      exp.csr_v = (op == e_system_op);
      exp.fence_v = (op == e_misc_mem_op && pkt.instr.i.funct3 <= 3'd1)
                    || (op == e_system_op && pkt.instr.i.funct3 == 3'd0
                        && pkt.instr.i.imm[11:5] == 7'b0001001 && pkt.instr.i.rd == 5'd0);
      // every m operation except plain mul goes to the long unit
      exp.long_v = op inside {e_op_op, e_op_32_op} && pkt.instr.r.funct7 == 7'd1
                   && pkt.instr.r.funct3 != 3'd0;
      exp.iwb_v = pkt.instr.r.rd != 5'd0 && !(op inside {e_branch_op, e_store_op, e_misc_mem_op});
    end
    return exp;
  endfunction

  task automatic check(input logic [127:0] got, input logic [127:0] exp, input string msg);
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      $display("Finished with errors");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic make_pkt(input msg_type_e kind, output fe_packet_s pkt);
    instr_u w;
    w = $random(seed);
    w.r.opcode = op_table[$unsigned($random(seed)) % 14];
    if (($random(seed) & 3) == 0)
      w.r.rd = '0; // some writers target x0
    if (w.r.opcode inside {e_op_op, e_op_32_op} && ($random(seed) & 1))
      w.r.funct7 = funct7_muldiv;
    if (w.r.opcode == e_misc_mem_op)
      w.i.funct3 = 3'($random(seed) & 1);
    if (w.r.opcode == e_system_op && ($random(seed) & 1))
    begin
      w.i.imm[11:5] = funct7_sfence_vma;
      w.i.funct3    = 3'd0;
      w.i.rd        = 5'd0;
    end
    pkt.msg_type = kind;
    pkt.pc       = vaddr_width_gp'({$random(seed), $random(seed)});
    pkt.instr    = w;
  endtask

  // offers n packets, reads whenever a head is there and commits what was read
  task automatic stream(input int n, input bit rd_en, input bit dq_en, input bit exc);
    fe_packet_s pkt;
    int         sent;
    sent = 0;
    make_pkt(exc ? msg_type_e'($random(seed) & 3) : e_instr_fetch, pkt);
    while (sent < n || (rd_en && m_rd < model_q.size()) || (dq_en && model_q.size() > 0))
    begin
      fe_v_i      = (sent < n);
      fe_packet_i = pkt;
      read_v_i    = rd_en && m_rd < model_q.size();
      deq_v_i     = dq_en && m_rd > 0;
      @(negedge clk_i);
      if (took)
      begin
        sent++;
        make_pkt(exc ? msg_type_e'($random(seed) & 3) : e_instr_fetch, pkt);
      end
    end
    {fe_v_i, read_v_i, deq_v_i} = '0;
  endtask

  task automatic pulse(input bit rd, dq, rl, cl, inj, sup);
    {read_v_i, deq_v_i, roll_v_i, clr_v_i, inject_v_i, suppress_v_i} = {rd, dq, rl, cl, inj, sup};
    @(negedge clk_i);
    {read_v_i, deq_v_i, roll_v_i, clr_v_i, inject_v_i, suppress_v_i} = '0;
  endtask

  //////////////////////////////////////////////////
  // compare against the model, then advance it

  always @(posedge clk_i)
  begin : compare
    issue_pkt_s got, exp, nexp;
    fe_packet_s nxt;
    logic       head_v, ready;
    if (arst_n_i)
    begin
      head_v = m_rd < model_q.size();
      ready  = model_q.size() < els_lp && !suppress_v_i;
      exp = ref_issue(head_v ? model_q[m_rd] : fe_packet_s'('0),
                      head_v && !inject_v_i && !suppress_v_i);
      got = issue_pkt_o;
      if (!exp.v)
      begin
        got.pc    = '0; // pc and instr carry no meaning without v
        got.instr = '0;
      end
      check(got, exp, "issue packet");
      check(fe_ready_and_o, ready, "front-end ready");
      took = fe_v_i && ready;
      if (clr_v_i)
      begin
        model_q.delete();
        m_rd = 0;
      end
      else
      begin
        if (deq_v_i)
        begin
          void'(model_q.pop_front());
          m_rd--;
        end
        if (read_v_i)
        begin
          m_rd++;
          if (issue_pkt_o.v)
            reads++;
        end
        if (roll_v_i)
          m_rd = 0; // replay from the checkpoint
      end
      if (took)
        model_q.push_back(fe_packet_i);
      // the pre-issue port already decodes the head of the next cycle
      if (m_rd < model_q.size())
      begin
        nxt          = model_q[m_rd];
        nxt.msg_type = e_instr_fetch; // register needs ignore the message type
        nexp         = ref_issue(nxt, 1'b1);
        check(preissue_pkt_o, {nxt.instr, nexp.rs1_v, nexp.rs2_v}, "pre-issue packet");
      end
    end
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > limit_lp)
    begin
      $display("Timeout: the tests did not end within %0d cycles", limit_lp);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    fe_packet_s pkt;
    {fe_v_i, read_v_i, deq_v_i, roll_v_i, clr_v_i, inject_v_i, suppress_v_i} = '0;
    fe_packet_i = '0;
    arst_n_i    = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    stream(40, 1, 1, 0);
    check(reads, 40, "packets issued in order");

    stream(els_lp, 1, 0, 0); // every slot read, none committed
    make_pkt(e_instr_fetch, pkt);
    fe_packet_i = pkt;
    fe_v_i      = 1'b1;
    repeat (2) @(negedge clk_i);
    check(fe_ready_and_o, 0, "front-end ready while the queue is full");
    pulse(0, 1, 0, 0, 0, 0);
    while (!took)
      @(negedge clk_i);
    fe_v_i = 1'b0;
    stream(0, 1, 1, 0);

    stream(6, 0, 0, 0);
    pulse(1, 0, 0, 0, 0, 0);
    pulse(1, 1, 0, 0, 0, 0);
    pulse(1, 0, 0, 0, 0, 0);
    pulse(0, 0, 1, 0, 0, 0);
    stream(0, 1, 1, 0);

    stream(4, 0, 0, 0);
    pulse(1, 0, 0, 0, 0, 0);
    pulse(0, 0, 0, 1, 0, 0);
    stream(5, 1, 1, 0);

    stream(3, 0, 0, 0);
    pulse(0, 0, 0, 0, 1, 0);
    make_pkt(e_instr_fetch, pkt);
    fe_packet_i = pkt;
    fe_v_i      = 1'b1;
    pulse(0, 0, 0, 0, 0, 1);
    while (!took)
      @(negedge clk_i);
    fe_v_i = 1'b0;
    stream(0, 1, 1, 0);

    stream(12, 1, 1, 1); // exception messages mixed with fetches

    repeat (2) @(negedge clk_i);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

//--- verilog/iq_issue_queue.sv
`timescale 1ns/100ps

module iq_issue_queue
  #(parameter int queue_els_p = iq_queue_pkg::queue_els_gp)
  (input                                   clk_i
   , input                                 arst_n_i

   , input iq_queue_pkg::fe_packet_s       fe_packet_i
   , input                                 fe_v_i
   , output logic                          fe_ready_and_o

   , input                                 read_v_i
   , input                                 deq_v_i
   , input                                 roll_v_i
   , input                                 clr_v_i
   , input                                 inject_v_i
   , input                                 suppress_v_i

   , output iq_queue_pkg::preissue_pkt_s   preissue_pkt_o
   , output iq_queue_pkg::issue_pkt_s      issue_pkt_o
   );

  import iq_isa_pkg::*;
  import iq_queue_pkg::*;

  localparam int idx_width_lp = $clog2(queue_els_p);

  logic [idx_width_lp:0] wptr, rptr, rptr_n;
  logic                  empty, empty_n, full;
  logic                  enq, preissue_v;

  fe_packet_s    head_pkt;
  instr_u        next_instr;
  preissue_pkt_s preissue_r;

  assign fe_ready_and_o = ~full & ~suppress_v_i;
  assign enq            = fe_v_i & fe_ready_and_o;

  // reload the pre-issue register whenever the head is about to change
  assign preissue_v = (read_v_i & ~empty_n) | roll_v_i | (enq & empty);

  //////////////////////////////////////////////////
  // pointers and storage

  iq_ptrs #(.queue_els_p(queue_els_p)) i_iq_ptrs
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .enq_i(enq)
     , .read_i(read_v_i)
     , .deq_i(deq_v_i)
     , .roll_i(roll_v_i)
     , .clr_i(clr_v_i)
     , .wptr_o(wptr)
     , .rptr_o(rptr)
     , .cptr_o()             // checkpoint is only needed inside the pointer block
     , .rptr_n_o(rptr_n)
     , .empty_o(empty)
     , .empty_n_o(empty_n)
     , .full_o(full)
     );

  iq_fifo_mem #(.queue_els_p(queue_els_p)) i_iq_fifo_mem
    (.clk_i(clk_i)
     , .w_v_i(enq)
     , .w_addr_i(wptr[idx_width_lp-1:0])
     , .w_data_i(fe_packet_i)
     , .head_addr_i(rptr[idx_width_lp-1:0])
     , .next_addr_i(rptr_n[idx_width_lp-1:0])
     , .head_o(head_pkt)
     , .next_instr_o(next_instr)
     );

  //////////////////////////////////////////////////
  // decode

  iq_predecode i_iq_predecode
    (.clk_i(clk_i)
     , .arst_n_i(arst_n_i)
     , .instr_i(next_instr)
     , .preissue_v_i(preissue_v)
     , .preissue_pkt_o(preissue_pkt_o)
     , .preissue_r_o(preissue_r)
     );

  iq_issue_decode i_iq_issue_decode
    (.head_i(head_pkt)
     , .preissue_r_i(preissue_r)
     , .empty_i(empty)
     , .inject_i(inject_v_i)
     , .suppress_i(suppress_v_i)
     , .issue_pkt_o(issue_pkt_o)
     );

endmodule

//--- verilog/iq_issue_decode.sv
`timescale 1ns/100ps

module iq_issue_decode
  (input iq_queue_pkg::fe_packet_s        head_i
   , input iq_queue_pkg::preissue_pkt_s   preissue_r_i
   , input                                empty_i
   , input                                inject_i
   , input                                suppress_i

   , output iq_queue_pkg::issue_pkt_s     issue_pkt_o
   );

  import iq_isa_pkg::*;
  import iq_queue_pkg::*;

  instr_u instr;
  logic   pkt_v, fetch_v;
  logic   is_fence, is_sfence, is_long, is_iwb;

  assign instr   = preissue_r_i.instr; // loaded together with the head
  assign pkt_v   = ~empty_i & ~inject_i & ~suppress_i;
  assign fetch_v = pkt_v & (head_i.msg_type == e_instr_fetch);

  //////////////////////////////////////////////////
  // instruction class decode

  assign is_fence  = (instr.i.opcode == e_misc_mem_op)
                     & (instr.i.funct3 inside {funct3_fence, funct3_fence_i});
  assign is_sfence = (instr.i.opcode == e_system_op) & (instr.i.funct3 == funct3_priv)
                     & (instr.i.imm[11:5] == funct7_sfence_vma) & (instr.i.rd == '0);

  // plain mul and mulw finish in the pipe, everything else in m goes long
  assign is_long = (instr.r.opcode inside {e_op_op, e_op_32_op})
                   & (instr.r.funct7 == funct7_muldiv)
                   & (instr.r.funct3 inside {funct3_mulh, funct3_mulhsu, funct3_mulhu,
                                             funct3_div, funct3_divu, funct3_rem, funct3_remu});

  assign is_iwb = (instr.r.rd != '0)
                  & (instr.r.opcode inside {e_lui_op, e_auipc_op, e_jal_op, e_jalr_op,
                                            e_load_op, e_op_imm_op, e_op_op, e_system_op,
                                            e_op_imm_32_op, e_op_32_op, e_amo_op});

  always_comb
  begin
    issue_pkt_o = '0;

    issue_pkt_o.v              = pkt_v;
    issue_pkt_o.instr_v        = fetch_v;
    issue_pkt_o.itlb_miss_v    = pkt_v & (head_i.msg_type == e_itlb_miss);
    issue_pkt_o.access_fault_v = pkt_v & (head_i.msg_type == e_access_fault);
    issue_pkt_o.page_fault_v   = pkt_v & (head_i.msg_type == e_page_fault);

    issue_pkt_o.pc    = head_i.pc;
    issue_pkt_o.instr = instr;

    issue_pkt_o.rs1_v = fetch_v & preissue_r_i.rs1_v;
    issue_pkt_o.rs2_v = fetch_v & preissue_r_i.rs2_v;

    issue_pkt_o.iwb_v   = fetch_v & is_iwb;
    issue_pkt_o.mem_v   = fetch_v
                          & (instr.r.opcode inside {e_load_op, e_store_op, e_amo_op, e_system_op});
    issue_pkt_o.csr_v   = fetch_v & (instr.r.opcode == e_system_op);
    issue_pkt_o.fence_v = fetch_v & (is_fence | is_sfence);
    issue_pkt_o.long_v  = fetch_v & is_long;
  end

endmodule

//--- verilog/iq_predecode.sv
`timescale 1ns/100ps

module iq_predecode
  (input                                   clk_i
   , input                                 arst_n_i

   , input iq_isa_pkg::instr_u             instr_i
   , input                                 preissue_v_i

   , output iq_queue_pkg::preissue_pkt_s   preissue_pkt_o
   , output iq_queue_pkg::preissue_pkt_s   preissue_r_o
   );

  import iq_isa_pkg::*;
  import iq_queue_pkg::*;

  always_comb
  begin
    preissue_pkt_o       = '0;
    preissue_pkt_o.instr = instr_i;

    // which integer sources the next head will read
    case (instr_i.r.opcode)
      e_jalr_op, e_load_op, e_op_imm_op, e_op_imm_32_op, e_system_op:
      begin
        preissue_pkt_o.rs1_v = 1'b1;
      end
      e_branch_op, e_store_op, e_op_op, e_op_32_op, e_amo_op:
      begin
        preissue_pkt_o.rs1_v = 1'b1;
        preissue_pkt_o.rs2_v = 1'b1;
      end
      default:
      begin
        preissue_pkt_o.rs1_v = 1'b0; // lui, auipc, jal and fences read nothing
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      preissue_r_o <= '0;
    else if (preissue_v_i)
      preissue_r_o <= preissue_pkt_o;
  end

endmodule

//--- verilog/iq_fifo_mem.sv
`timescale 1ns/100ps

module iq_fifo_mem
  #(parameter int queue_els_p = iq_queue_pkg::queue_els_gp
    , localparam int addr_width_lp = $clog2(queue_els_p)
    )
  (input                                clk_i

   , input                              w_v_i
   , input [addr_width_lp-1:0]          w_addr_i
   , input iq_queue_pkg::fe_packet_s    w_data_i

   , input [addr_width_lp-1:0]          head_addr_i
   , input [addr_width_lp-1:0]          next_addr_i

   , output iq_queue_pkg::fe_packet_s   head_o
   , output iq_isa_pkg::instr_u         next_instr_o
   );

  import iq_queue_pkg::*;

  fe_packet_s mem_r [queue_els_p];
  logic       bypass_next;

  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
      mem_r[w_addr_i] <= w_data_i;
  end

  // head port reads the registered read slot
  assign head_o = mem_r[head_addr_i];

  // the next head may be the packet arriving this very cycle
  assign bypass_next = w_v_i & (next_addr_i == w_addr_i);

  always_comb
  begin
    if (bypass_next)
      next_instr_o = w_data_i.instr;
    else
      next_instr_o = mem_r[next_addr_i].instr;
  end

endmodule

//--- verilog/iq_ptrs.sv
`timescale 1ns/100ps

module iq_ptrs
  #(parameter int queue_els_p = iq_queue_pkg::queue_els_gp
    , localparam int idx_width_lp = $clog2(queue_els_p)
    )
  (input                         clk_i
   , input                       arst_n_i

   , input                       enq_i
   , input                       read_i
   , input                       deq_i
   , input                       roll_i
   , input                       clr_i

   , output logic [idx_width_lp:0] wptr_o
   , output logic [idx_width_lp:0] rptr_o
   , output logic [idx_width_lp:0] cptr_o
   , output logic [idx_width_lp:0] rptr_n_o

   , output logic                empty_o
   , output logic                empty_n_o
   , output logic                full_o
   );

  // top bit of each pointer is the wrap bit
  typedef logic [idx_width_lp:0] ptr_t;

  ptr_t wptr_r, rptr_r, cptr_r;
  ptr_t wptr_n, rptr_n, cptr_n;

  always_comb
  begin
    wptr_n = wptr_r + ptr_t'(enq_i);
    cptr_n = cptr_r + ptr_t'(deq_i);
    rptr_n = roll_i ? cptr_n : rptr_r + ptr_t'(read_i); // roll replays from checkpoint
    if (clr_i)
    begin
      wptr_n = '0;
      rptr_n = '0;
      cptr_n = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r <= '0;
      rptr_r <= '0;
      cptr_r <= '0;
    end
    else
    begin
      wptr_r <= wptr_n;
      rptr_r <= rptr_n;
      cptr_r <= cptr_n;
    end
  end

  assign empty_o   = (rptr_r == wptr_r);
  assign empty_n_o = (rptr_n == wptr_n);
  // same slot but one lap apart means every slot waits for commit
  assign full_o    = (cptr_r[idx_width_lp-1:0] == wptr_r[idx_width_lp-1:0])
                     & (cptr_r[idx_width_lp] != wptr_r[idx_width_lp]);

  assign wptr_o   = wptr_r;
  assign rptr_o   = rptr_r;
  assign cptr_o   = cptr_r;
  assign rptr_n_o = rptr_n;

  //////////////////////////////////////////////////
  // protocol checks on the strobes from the top and the back end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) !(enq_i && full_o))
    else $error("enqueue into a full queue");

  assert property (@(posedge clk_i) disable iff (!arst_n_i) !(read_i && empty_o))
    else $error("issue read from an empty queue");

  // commit may only retire entries that have already been read
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
                   (deq_i && !clr_i) |-> (cptr_r != rptr_r))
    else $error("dequeue passes the read pointer");

endmodule

//--- verilog/iq_queue_pkg.sv
package iq_queue_pkg;

  localparam int vaddr_width_gp = 39;
  localparam int queue_els_gp   = 8; // must stay a power of two

  // what the front end is telling us about this pc
  typedef enum logic [1:0]
  {
    e_instr_fetch    = 2'b00
    , e_itlb_miss    = 2'b01
    , e_access_fault = 2'b10
    , e_page_fault   = 2'b11
  } msg_type_e;

  typedef struct packed
  {
    msg_type_e                 msg_type;
    logic [vaddr_width_gp-1:0] pc;
    iq_isa_pkg::instr_u        instr;
  } fe_packet_s;

  // register read needs of the next head, known a cycle early
  typedef struct packed
  {
    iq_isa_pkg::instr_u instr;
    logic               rs1_v;
    logic               rs2_v;
  } preissue_pkt_s;

  typedef struct packed
  {
    logic v;
    logic instr_v;
    logic itlb_miss_v;
    logic access_fault_v;
    logic page_fault_v;

    logic [vaddr_width_gp-1:0] pc;
    iq_isa_pkg::instr_u        instr;

    logic rs1_v;
    logic rs2_v;

    logic iwb_v;   // integer writeback to a nonzero rd
    logic mem_v;
    logic csr_v;
    logic fence_v;
    logic long_v;  // multi-cycle mul/div unit
  } issue_pkt_s;

endpackage

//--- verilog/iq_isa_pkg.sv
package iq_isa_pkg;

  // major opcodes of the rv64 integer isa
  typedef enum logic [6:0]
  {
    e_lui_op       = 7'b0110111
    , e_auipc_op     = 7'b0010111
    , e_jal_op       = 7'b1101111
    , e_jalr_op      = 7'b1100111
    , e_branch_op    = 7'b1100011
    , e_load_op      = 7'b0000011
    , e_store_op     = 7'b0100011
    , e_op_imm_op    = 7'b0010011
    , e_op_imm_32_op = 7'b0011011
    , e_op_op        = 7'b0110011
    , e_op_32_op     = 7'b0111011
    , e_misc_mem_op  = 7'b0001111
    , e_system_op    = 7'b1110011
    , e_amo_op       = 7'b0101111
  } opcode_e;

  typedef struct packed
  {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } rtype_s;

  typedef struct packed
  {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } itype_s;

  // the same word seen as register-register or as immediate format
  typedef union packed
  {
    rtype_s r;
    itype_s i;
  } instr_u;

  localparam logic [6:0] funct7_muldiv     = 7'b0000001;
  localparam logic [6:0] funct7_sfence_vma = 7'b0001001; // upper imm bits of sfence.vma

  localparam logic [2:0] funct3_mulh   = 3'b001;
  localparam logic [2:0] funct3_mulhsu = 3'b010;
  localparam logic [2:0] funct3_mulhu  = 3'b011;
  localparam logic [2:0] funct3_div    = 3'b100; // also divw in op_32
  localparam logic [2:0] funct3_divu   = 3'b101;
  localparam logic [2:0] funct3_rem    = 3'b110;
  localparam logic [2:0] funct3_remu   = 3'b111;

  localparam logic [2:0] funct3_fence   = 3'b000;
  localparam logic [2:0] funct3_fence_i = 3'b001;
  localparam logic [2:0] funct3_priv    = 3'b000;

endpackage
